/* hdl/cache_pkg.sv */
////////////////////
// cache package
// fixed widths, data types and the state and opcode
// enums shared by the four-way cache blocks
////////////////////
package cache_pkg;

    ////////////////////
    // fixed sizes
    ////////////////////
    localparam int ADDR_WIDTH      = 16;
    localparam int WORD_WIDTH      = 16;
    localparam int WORDS_PER_BLOCK = 8;
    localparam int OFFSET_WIDTH    = 3;
    localparam int NUM_WAYS        = 4;   // victim choice assumes four
    localparam int BYTES_PER_BLOCK = WORDS_PER_BLOCK * WORD_WIDTH / 8;

    ////////////////////
    // data types
    ////////////////////
    typedef logic [ADDR_WIDTH-1:0]                 addr_t;
    typedef logic [WORD_WIDTH-1:0]                 word_t;
    typedef logic [7:0]                            byte_t;
    typedef logic [WORDS_PER_BLOCK*WORD_WIDTH-1:0] block_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]           way_t;
    typedef logic [1:0]                            lru_cnt_t;

    // decoded cpu request
    typedef enum logic [1:0] {op_read, op_write, op_invalid} req_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_evict,
        st_fill,
        st_install
    } ctrl_state_e;

    // one byte on the memory port
    typedef enum logic [1:0] {xs_idle, xs_request, xs_wait_ack} xfer_state_e;

endpackage

/* hdl/cache_array_if.sv */
////////////////////
// controller to tag/data array link
// request fields, word write, block install and
// the hit and victim view of the addressed set
////////////////////
interface cache_array_if #(parameter int INDEX_WIDTH = 8);

    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH - 1;

    logic [INDEX_WIDTH-1:0]             index;
    logic [TAG_WIDTH-1:0]               tag;
    logic [cache_pkg::OFFSET_WIDTH-1:0] offset;
    cache_pkg::word_t                   write_word;
    logic                               write_en;   // word into hit way, sets dirty
    logic                               access;     // hit completes, bumps counter
    cache_pkg::block_t                  fill_block;
    logic                               install;    // fill_block into victim way
    logic                               hit;
    cache_pkg::word_t                   read_word;
    cache_pkg::block_t                  victim_block;
    logic [TAG_WIDTH-1:0]               victim_tag;
    logic                               victim_dirty;

    modport ctrl (
        output index, tag, offset, write_word, write_en, access, fill_block, install,
        input  hit, read_word, victim_block, victim_tag, victim_dirty
    );

    modport array (
        input  index, tag, offset, write_word, write_en, access, fill_block, install,
        output hit, read_word, victim_block, victim_tag, victim_dirty
    );

endinterface

/* hdl/block_xfer_if.sv */
////////////////////
// controller to block mover link
// start pulses, block addresses and data, done pulse
////////////////////
interface block_xfer_if #(parameter int INDEX_WIDTH = 8);

    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH - 1;

    // block base addresses carry tag and index only, the byte bits are zero
    logic                             evict_start;
    logic                             fill_start;
    logic [TAG_WIDTH+INDEX_WIDTH-1:0] evict_addr;
    logic [TAG_WIDTH+INDEX_WIDTH-1:0] fill_addr;
    cache_pkg::block_t                evict_block;
    cache_pkg::block_t                fill_block;
    logic                             done;

    modport ctrl (
        output evict_start, fill_start, evict_addr, fill_addr, evict_block,
        input  fill_block, done
    );

    modport mover (
        input  evict_start, fill_start, evict_addr, fill_addr, evict_block,
        output fill_block, done
    );

endinterface

/* hdl/cache_array.sv */
////////////////////
// four-way tag/data array
// tag, block, valid, dirty and access counter per way,
// combinational hit and victim selection for one set,
// word writes and block installs at the clock edge
////////////////////
module cache_array #(parameter int INDEX_WIDTH = 8)
(
    input  logic         clk,
    input  logic         reset,
    cache_array_if.array arr
);

    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH - 1;
    localparam int NUM_SETS  = 1 << INDEX_WIDTH;
    localparam int NUM_WAYS  = cache_pkg::NUM_WAYS;

    ////////////////////
    // storage
    ////////////////////
    cache_pkg::block_t    data_mem [NUM_SETS][NUM_WAYS];
    logic [TAG_WIDTH-1:0] tag_mem  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]  valid_q  [NUM_SETS];
    logic [NUM_WAYS-1:0]  dirty_q  [NUM_SETS];
    cache_pkg::lru_cnt_t  lru_q    [NUM_SETS][NUM_WAYS];

    logic                 hit_any;
    cache_pkg::way_t      hit_way;
    cache_pkg::way_t      victim;

    // tag compare across the addressed set
    always_comb
    begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (valid_q[arr.index][w] && tag_mem[arr.index][w] == arr.tag)
            begin
                hit_any = 1'b1;
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    // lowest invalid way first, else smallest counter
    always_comb
    begin
        victim = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (!valid_q[arr.index][w])
                victim = cache_pkg::way_t'(w);
        end
        if (&valid_q[arr.index])
        begin
            for (int w = 1; w < NUM_WAYS; w++)
            begin
                if (lru_q[arr.index][w] < lru_q[arr.index][victim])   // strict, tie keeps lower
                    victim = cache_pkg::way_t'(w);
            end
        end
    end

    assign arr.hit          = hit_any;
    assign arr.read_word    =
        data_mem[arr.index][hit_way][arr.offset*cache_pkg::WORD_WIDTH +: cache_pkg::WORD_WIDTH];
    assign arr.victim_block = data_mem[arr.index][victim];
    assign arr.victim_tag   = tag_mem[arr.index][victim];
    assign arr.victim_dirty = valid_q[arr.index][victim] & dirty_q[arr.index][victim];

    ////////////////////
    // state bits
    ////////////////////
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                for (int w = 0; w < NUM_WAYS; w++)
                    lru_q[s][w] <= '0;
            end
        end
        else if (arr.install)
        begin
            valid_q[arr.index][victim] <= 1'b1;
            dirty_q[arr.index][victim] <= 1'b0;
            lru_q[arr.index][victim]   <= '0;
        end
        else if (hit_any)
        begin
            if (arr.write_en)
                dirty_q[arr.index][hit_way] <= 1'b1;
            if (arr.access)
                lru_q[arr.index][hit_way] <= lru_q[arr.index][hit_way] + 1'b1;   // wraps
        end
    end

    // tags and blocks
    always_ff @(posedge clk)
    begin
        if (arr.install)
        begin
            data_mem[arr.index][victim] <= arr.fill_block;
            tag_mem[arr.index][victim]  <= arr.tag;
        end
        else if (arr.write_en && hit_any)
        begin
            data_mem[arr.index][hit_way][arr.offset*cache_pkg::WORD_WIDTH +: cache_pkg::WORD_WIDTH]
                <= arr.write_word;
        end
    end

endmodule

/* hdl/cache_ctrl.sv */
////////////////////
// cache request controller
// decodes cpu strobes, compares tags, runs eviction
// and fill through the block mover, installs the block
////////////////////
module cache_ctrl #(parameter int INDEX_WIDTH = 8)
(
    input  logic              clk,
    input  logic              reset,
    input  cache_pkg::addr_t  cpu_addr_in,
    input  logic              cpu_req_read,
    input  logic              cpu_req_write,
    input  logic              cpu_req_ready,
    input  cache_pkg::word_t  cpu_data_in,
    output cache_pkg::word_t  cpu_data_out,
    output logic              cpu_data_ready,
    output logic              cpu_stall_req,
    output logic              cpu_req_invalid,
    cache_array_if.ctrl       arr,
    block_xfer_if.ctrl        xfer
);

    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH - 1;

    cache_pkg::ctrl_state_e             state;
    cache_pkg::req_op_e                 op_q;
    cache_pkg::req_op_e                 op_dec;
    logic [TAG_WIDTH-1:0]               tag_q;
    logic [INDEX_WIDTH-1:0]             index_q;
    logic [cache_pkg::OFFSET_WIDTH-1:0] offset_q;
    cache_pkg::word_t                   wdata_q;
    logic                               take_req;
    logic                               hit_now;
    logic                               miss_now;

    // skip the cycle of our own response pulse, cpu drops ready after it
    assign take_req = state == cache_pkg::st_idle && cpu_req_ready
                      && !cpu_data_ready && !cpu_req_invalid;
    assign hit_now  = state == cache_pkg::st_compare && arr.hit;
    assign miss_now = state == cache_pkg::st_compare && !arr.hit;

    always_comb
    begin
        if (cpu_req_read && cpu_req_write)
            op_dec = cache_pkg::op_invalid;
        else if (cpu_req_write)
            op_dec = cache_pkg::op_write;
        else if (cpu_req_read)
            op_dec = cache_pkg::op_read;
        else
            op_dec = cache_pkg::op_invalid;   // ready with no strobe
    end

    ////////////////////
    // array and mover
    ////////////////////
    assign arr.index        = index_q;
    assign arr.tag          = tag_q;
    assign arr.offset       = offset_q;
    assign arr.write_word   = wdata_q;
    assign arr.access       = hit_now;
    assign arr.write_en     = hit_now && op_q == cache_pkg::op_write;
    assign arr.install      = state == cache_pkg::st_install;
    assign arr.fill_block   = xfer.fill_block;

    assign xfer.evict_start = miss_now && arr.victim_dirty;
    assign xfer.fill_start  = (miss_now && !arr.victim_dirty)
                              || (state == cache_pkg::st_evict && xfer.done);
    assign xfer.evict_addr  = {arr.victim_tag, index_q};
    assign xfer.fill_addr   = {tag_q, index_q};
    assign xfer.evict_block = arr.victim_block;

    // FSM
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state           <= cache_pkg::st_idle;
            op_q            <= cache_pkg::op_read;
            cpu_data_ready  <= 1'b0;
            cpu_stall_req   <= 1'b0;
            cpu_req_invalid <= 1'b0;
        end
        else
        begin
            cpu_data_ready  <= 1'b0;
            cpu_req_invalid <= 1'b0;
            case (state)
                cache_pkg::st_idle:
                    if (take_req)
                    begin
                        op_q <= op_dec;
                        if (op_dec == cache_pkg::op_invalid)
                            cpu_req_invalid <= 1'b1;   // no array access
                        else
                            state <= cache_pkg::st_compare;
                    end
                cache_pkg::st_compare:
                    if (arr.hit)
                    begin
                        cpu_data_ready <= 1'b1;
                        cpu_stall_req  <= 1'b0;
                        state          <= cache_pkg::st_idle;
                    end
                    else
                    begin
                        cpu_stall_req <= 1'b1;
                        state <= arr.victim_dirty ? cache_pkg::st_evict : cache_pkg::st_fill;
                    end
                cache_pkg::st_evict:
                    if (xfer.done)
                        state <= cache_pkg::st_fill;
                cache_pkg::st_fill:
                    if (xfer.done)
                        state <= cache_pkg::st_install;
                cache_pkg::st_install:
                    state <= cache_pkg::st_compare;   // now hits
                default:
                    state <= cache_pkg::st_idle;
            endcase
        end
    end

    // request fields and read data
    always_ff @(posedge clk)
    begin
        if (take_req)
        begin
            tag_q    <= cpu_addr_in[cache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
            index_q  <= cpu_addr_in[cache_pkg::OFFSET_WIDTH+1 +: INDEX_WIDTH];
            offset_q <= cpu_addr_in[1 +: cache_pkg::OFFSET_WIDTH];
            wdata_q  <= cpu_data_in;
        end
        if (hit_now && op_q == cache_pkg::op_read)
            cpu_data_out <= arr.read_word;
    end

endmodule

/* hdl/block_mover.sv */
////////////////////
// memory block mover
// writes an evicted block or reads a fill block
// one byte per request/ack on the memory port
////////////////////
module block_mover #(parameter int INDEX_WIDTH = 8)
(
    input  logic              clk,
    input  logic              reset,
    block_xfer_if.mover       xfer,
    input  cache_pkg::byte_t  mem_data_read,
    input  logic              mem_ack,
    output cache_pkg::addr_t  mem_addr,
    output cache_pkg::byte_t  mem_data_write,
    output logic              mem_read_enable,
    output logic              mem_write_enable,
    output logic              mem_req_valid
);

    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH - 1;
    localparam int BLK_WIDTH = TAG_WIDTH + INDEX_WIDTH;
    localparam int CNT_WIDTH = $clog2(cache_pkg::BYTES_PER_BLOCK);

    cache_pkg::xfer_state_e state;
    logic                   writing;    // eviction in progress
    logic [CNT_WIDTH-1:0]   byte_cnt;
    logic [BLK_WIDTH-1:0]   blk_q;
    cache_pkg::block_t      buf_q;
    logic                   start;
    logic                   last_byte;

    assign start     = state == cache_pkg::xs_idle && (xfer.evict_start || xfer.fill_start);
    assign last_byte = byte_cnt == CNT_WIDTH'(cache_pkg::BYTES_PER_BLOCK - 1);

    // address settles a cycle before the request rises
    assign mem_req_valid    = state == cache_pkg::xs_wait_ack;
    assign mem_write_enable = mem_req_valid && writing;
    assign mem_read_enable  = mem_req_valid && !writing;
    assign mem_addr         = {blk_q, byte_cnt};
    assign mem_data_write   = buf_q[byte_cnt*8 +: 8];   // low byte at even address
    assign xfer.fill_block  = buf_q;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state     <= cache_pkg::xs_idle;
            writing   <= 1'b0;
            byte_cnt  <= '0;
            xfer.done <= 1'b0;
        end
        else
        begin
            xfer.done <= 1'b0;
            case (state)
                cache_pkg::xs_idle:
                    if (start)
                    begin
                        writing  <= xfer.evict_start;
                        byte_cnt <= '0;
                        state    <= cache_pkg::xs_request;
                    end
                cache_pkg::xs_request:
                    state <= cache_pkg::xs_wait_ack;
                cache_pkg::xs_wait_ack:
                    if (mem_ack)
                    begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (last_byte)
                        begin
                            xfer.done <= 1'b1;
                            state     <= cache_pkg::xs_idle;
                        end
                        else
                            state <= cache_pkg::xs_request;
                    end
                default:
                    state <= cache_pkg::xs_idle;
            endcase
        end
    end

    // block address and byte buffer
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            blk_q <= xfer.fill_start ? xfer.fill_addr : xfer.evict_addr;
            if (xfer.evict_start)
                buf_q <= xfer.evict_block;
        end
        else if (state == cache_pkg::xs_wait_ack && mem_ack && !writing)
            buf_q[byte_cnt*8 +: 8] <= mem_data_read;
    end

endmodule

/* hdl/cache_top.sv */
////////////////////
// four-way write-back cache, top level
// cpu word port and byte-wide memory port
////////////////////
module cache_top #(parameter int INDEX_WIDTH = 8)
(
    input  logic              clk,
    input  logic              reset,
    input  cache_pkg::addr_t  cpu_addr_in,
    input  logic              cpu_req_read,
    input  logic              cpu_req_write,
    input  logic              cpu_req_ready,
    input  cache_pkg::word_t  cpu_data_in,
    output cache_pkg::word_t  cpu_data_out,
    output logic              cpu_data_ready,
    output logic              cpu_stall_req,
    output logic              cpu_req_invalid,
    input  cache_pkg::byte_t  mem_data_read,
    input  logic              mem_ack,
    output cache_pkg::addr_t  mem_addr,
    output cache_pkg::byte_t  mem_data_write,
    output logic              mem_read_enable,
    output logic              mem_write_enable,
    output logic              mem_req_valid
);

    cache_array_if #(.INDEX_WIDTH(INDEX_WIDTH)) arr_bus ();
    block_xfer_if  #(.INDEX_WIDTH(INDEX_WIDTH)) xfer_bus ();

    cache_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) i_ctrl (
        .clk             (clk),
        .reset           (reset),
        .cpu_addr_in     (cpu_addr_in),
        .cpu_req_read    (cpu_req_read),
        .cpu_req_write   (cpu_req_write),
        .cpu_req_ready   (cpu_req_ready),
        .cpu_data_in     (cpu_data_in),
        .cpu_data_out    (cpu_data_out),
        .cpu_data_ready  (cpu_data_ready),
        .cpu_stall_req   (cpu_stall_req),
        .cpu_req_invalid (cpu_req_invalid),
        .arr             (arr_bus.ctrl),
        .xfer            (xfer_bus.ctrl)
    );

    cache_array #(.INDEX_WIDTH(INDEX_WIDTH)) i_array (
        .clk   (clk),
        .reset (reset),
        .arr   (arr_bus.array)
    );

    block_mover #(.INDEX_WIDTH(INDEX_WIDTH)) i_mover (
        .clk              (clk),
        .reset            (reset),
        .xfer             (xfer_bus.mover),
        .mem_data_read    (mem_data_read),
        .mem_ack          (mem_ack),
        .mem_addr         (mem_addr),
        .mem_data_write   (mem_data_write),
        .mem_read_enable  (mem_read_enable),
        .mem_write_enable (mem_write_enable),
        .mem_req_valid    (mem_req_valid)
    );

endmodule

/* bench/tb_clock.sv */
////////////////////
// testbench clock and reset
// free running clock, reset high for the first cycles
////////////////////
module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
)
(
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES)
            @(posedge clk);
        #2 reset = 1'b0;   // released like any other input
    end

endmodule

/* bench/tb_cache.sv */
////////////////////
// testbench for the four-way cache
// byte memory model with random ack delay, shadow word
// copy of memory as reference, directed and random cpu
// traffic over a few crowded sets, watchdog
////////////////////
module tb_cache;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 40;
    localparam int INDEX_WIDTH     = 4;
    localparam int NUM_REQUESTS    = 206;   // directed 6, random 200
    localparam int WATCHDOG_CYCLES = 400 * NUM_REQUESTS + 100;

    logic              clk;
    logic              reset;
    cache_pkg::addr_t  cpu_addr_in;
    logic              cpu_req_read;
    logic              cpu_req_write;
    logic              cpu_req_ready;
    cache_pkg::word_t  cpu_data_in;
    cache_pkg::word_t  cpu_data_out;
    logic              cpu_data_ready;
    logic              cpu_stall_req;
    logic              cpu_req_invalid;
    cache_pkg::byte_t  mem_data_read;
    logic              mem_ack;
    cache_pkg::addr_t  mem_addr;
    cache_pkg::byte_t  mem_data_write;
    logic              mem_read_enable;
    logic              mem_write_enable;
    logic              mem_req_valid;

    cache_pkg::byte_t   mem       [65536];
    cache_pkg::word_t   shadow    [32768];   // expected memory image, word view
    logic               cpu_wrote [4096];    // per block, set by any cpu write
    cache_pkg::req_op_e pend_op = cache_pkg::op_read;
    cache_pkg::addr_t   pend_addr = '0;
    cache_pkg::addr_t   held_addr = '0;
    integer             seed = 22;
    int                 ack_wait = 0;
    int                 mem_acks = 0;
    int                 checks_done = 0;

    tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) i_clock (
        .clk   (clk),
        .reset (reset)
    );

    cache_top #(.INDEX_WIDTH(INDEX_WIDTH)) i_dut (
        .clk              (clk),
        .reset            (reset),
        .cpu_addr_in      (cpu_addr_in),
        .cpu_req_read     (cpu_req_read),
        .cpu_req_write    (cpu_req_write),
        .cpu_req_ready    (cpu_req_ready),
        .cpu_data_in      (cpu_data_in),
        .cpu_data_out     (cpu_data_out),
        .cpu_data_ready   (cpu_data_ready),
        .cpu_stall_req    (cpu_stall_req),
        .cpu_req_invalid  (cpu_req_invalid),
        .mem_data_read    (mem_data_read),
        .mem_ack          (mem_ack),
        .mem_addr         (mem_addr),
        .mem_data_write   (mem_data_write),
        .mem_read_enable  (mem_read_enable),
        .mem_write_enable (mem_write_enable),
        .mem_req_valid    (mem_req_valid)
    );

    ////////////////////
    // reference and checks
    ////////////////////
    // low byte xor 5a, folded with the high byte
    function automatic cache_pkg::byte_t pattern_byte(input cache_pkg::addr_t a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    function automatic cache_pkg::word_t expected_word(input cache_pkg::addr_t a);
        return shadow[a[15:1]];
    endfunction

    // low byte of a word sits at the even address
    function automatic cache_pkg::byte_t expected_byte(input cache_pkg::addr_t a);
        cache_pkg::word_t w;
        w = shadow[a[15:1]];
        return a[0] ? w[15:8] : w[7:0];
    endfunction

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_word(input string name, input cache_pkg::word_t actual,
                              input cache_pkg::word_t expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input cache_pkg::byte_t actual,
                              input cache_pkg::byte_t expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0d ns: %s is %b, expected %b", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t actual,
                              input cache_pkg::addr_t expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // read data, checked just after the edge that raises cpu_data_ready
    always
    begin
        @(posedge clk);
        #1;
        if (cpu_data_ready)
        begin
            check_bit("cpu_data_ready on invalid request", pend_op == cache_pkg::op_invalid, 1'b0);
            if (pend_op == cache_pkg::op_read)
            begin
                check_word("cpu_data_out", cpu_data_out, expected_word(pend_addr));
                checks_done++;
            end
        end
    end

    ////////////////////
    // memory model
    ////////////////////
    always
    begin
        @(posedge clk);
        #2;
        if (mem_ack)
            mem_ack = 1'b0;   // one cycle pulse
        else if (mem_req_valid)
        begin
            if (ack_wait == 0)
            begin
                ack_wait  = 1 + $unsigned($random(seed)) % 3;
                held_addr = mem_addr;
                check_bit("mem_read_enable xor mem_write_enable",
                          mem_read_enable ^ mem_write_enable, 1'b1);
            end
            check_addr("mem_addr", mem_addr, held_addr);   // steady until ack
            ack_wait--;
            if (ack_wait == 0)
            begin
                if (mem_write_enable)
                begin
                    check_bit("cpu write to evicted block", cpu_wrote[mem_addr[15:4]], 1'b1);
                    check_byte("mem_data_write", mem_data_write, expected_byte(mem_addr));
                    mem[mem_addr] = mem_data_write;
                end
                else
                begin
                    check_addr("fill block address", {mem_addr[15:4], 4'h0},
                               {pend_addr[15:4], 4'h0});
                    mem_data_read = mem[mem_addr];
                end
                mem_ack = 1'b1;
                mem_acks++;
            end
        end
    end

    ////////////////////
    // cpu side
    ////////////////////
    task automatic cpu_access(input cache_pkg::req_op_e op, input cache_pkg::addr_t addr,
                              input cache_pkg::word_t data, input logic expect_hit,
                              output logic saw_stall);
        int   cycles;
        logic finished;
        cycles    = 0;
        finished  = 1'b0;
        saw_stall = 1'b0;
        pend_op   = op;
        pend_addr = addr;
        if (op == cache_pkg::op_write)
        begin
            shadow[addr[15:1]]    = data;
            cpu_wrote[addr[15:4]] = 1'b1;
        end
        cpu_addr_in   = addr;
        cpu_data_in   = data;
        cpu_req_read  = op == cache_pkg::op_read;
        cpu_req_write = op == cache_pkg::op_write;
        cpu_req_ready = 1'b1;
        while (!finished)
        begin
            @(posedge clk);
            #2;
            cycles++;
            check_bit("cpu_req_invalid", cpu_req_invalid, 1'b0);
            if (expect_hit)
            begin
                check_bit("cpu_data_ready", cpu_data_ready, cycles == 2);
                check_bit("mem_req_valid", mem_req_valid, 1'b0);
            end
            if (cpu_data_ready)
                finished = 1'b1;
            else
            begin
                check_bit("cpu_stall_req", cpu_stall_req, cycles >= 2);   // held until ready
                saw_stall = saw_stall | cpu_stall_req;
            end
        end
        cpu_req_ready = 1'b0;
        cpu_req_read  = 1'b0;
        cpu_req_write = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic invalid_access(input cache_pkg::addr_t addr);
        int mem_before;
        mem_before    = mem_acks;
        pend_op       = cache_pkg::op_invalid;
        pend_addr     = addr;
        cpu_addr_in   = addr;
        cpu_data_in   = 16'hdead;
        cpu_req_read  = 1'b1;
        cpu_req_write = 1'b1;
        cpu_req_ready = 1'b1;
        @(posedge clk);   // sampling edge
        #2;
        check_bit("cpu_req_invalid", cpu_req_invalid, 1'b1);
        cpu_req_ready = 1'b0;
        cpu_req_read  = 1'b0;
        cpu_req_write = 1'b0;
        repeat (4)
        begin
            @(posedge clk);
            #2;
            check_bit("cpu_req_invalid", cpu_req_invalid, 1'b0);
            check_bit("cpu_data_ready", cpu_data_ready, 1'b0);
            check_bit("mem_req_valid", mem_req_valid, 1'b0);
        end
        check_bit("memory access after invalid request", mem_acks == mem_before, 1'b1);
    endtask

    initial
    begin
        logic             stall;
        cache_pkg::addr_t addr;
        logic [7:0]       tag;
        logic [3:0]       idx;
        cache_pkg::req_op_e op;

        cpu_addr_in   = '0;
        cpu_req_read  = 1'b0;
        cpu_req_write = 1'b0;
        cpu_req_ready = 1'b0;
        cpu_data_in   = '0;
        mem_data_read = '0;
        mem_ack       = 1'b0;
        for (int a = 0; a < 65536; a++)
            mem[a] = pattern_byte(cache_pkg::addr_t'(a));
        for (int w = 0; w < 32768; w++)
            shadow[w] = {pattern_byte(cache_pkg::addr_t'(2 * w + 1)),
                         pattern_byte(cache_pkg::addr_t'(2 * w))};
        for (int b = 0; b < 4096; b++)
            cpu_wrote[b] = 1'b0;

        // outputs quiet after reset
        @(negedge reset);
        @(posedge clk);
        #2;
        check_bit("cpu_data_ready", cpu_data_ready, 1'b0);
        check_bit("cpu_req_invalid", cpu_req_invalid, 1'b0);
        check_bit("cpu_stall_req", cpu_stall_req, 1'b0);
        check_bit("mem_req_valid", mem_req_valid, 1'b0);
        check_bit("mem_read_enable", mem_read_enable, 1'b0);
        check_bit("mem_write_enable", mem_write_enable, 1'b0);

        // cold read miss
        cpu_access(cache_pkg::op_read, 16'h1234, '0, 1'b0, stall);
        check_bit("cpu_stall_req during miss", stall, 1'b1);

        // write allocate, then two hits
        cpu_access(cache_pkg::op_write, 16'h2468, 16'hbeef, 1'b0, stall);
        cpu_access(cache_pkg::op_read, 16'h2468, '0, 1'b1, stall);
        cpu_access(cache_pkg::op_read, 16'h2468, '0, 1'b1, stall);

        // six tags into sets 3 and 12, more than four ways
        for (int i = 0; i < 200; i++)
        begin
            tag  = 8'h21 + 8'($unsigned($random(seed)) % 6) * 8'h17;
            idx  = ($random(seed) & 1) ? 4'd12 : 4'd3;
            addr = {tag, idx, 3'($random(seed)), 1'b0};
            op   = ($random(seed) & 1) ? cache_pkg::op_write : cache_pkg::op_read;
            cpu_access(op, addr, cache_pkg::word_t'($random(seed)), 1'b0, stall);
        end

        invalid_access(16'h213a);
        cpu_access(cache_pkg::op_read, 16'h213a, '0, 1'b0, stall);

        if (checks_done == 0)
        begin
            $display("no read data was compared");
            abort_run();
        end
        else
        begin
            $display("All tests passed");
            $finish;
        end
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

/* build.f */
hdl/cache_pkg.sv
hdl/cache_array_if.sv
hdl/block_xfer_if.sv
hdl/cache_array.sv
hdl/cache_ctrl.sv
hdl/block_mover.sv
hdl/cache_top.sv
bench/tb_clock.sv
bench/tb_cache.sv
